// File: sim.f
rtl/gpr_pkg.sv
rtl/gpr_bank.sv
rtl/gpr_forward.sv
rtl/gpr_file.sv
verification/gpr_file_tb.sv

// File: Bender.yml
package:
  name: gpr_file

sources:
  - files:
      - rtl/gpr_pkg.sv
      - rtl/gpr_bank.sv
      - rtl/gpr_forward.sv
      - rtl/gpr_file.sv
  - target: simulation
    files:
      - verification/gpr_file_tb.sv

// File: verification/gpr_file_tb.sv
`default_nettype none

module gpr_file_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned NumRegs      = gpr_pkg::NUM_WORDS;
   localparam int unsigned CheckTimeout = 8;
   localparam int unsigned RandomCycles = 400;

   logic               clk = 1'b0;
   logic               rst = 1'b1;
   logic               padv_decode;
   gpr_pkg::gpr_addr_t rfa_adr;
   gpr_pkg::gpr_addr_t rfb_adr;
   gpr_pkg::gpr_addr_t rfd_adr;
   logic               rf_wb;
   logic               execute_rf_we;
   logic               write_mask;
   gpr_pkg::gpr_data_t result;
   gpr_pkg::gpr_data_t rfa;
   gpr_pkg::gpr_data_t rfb;

   // Reference register model
   gpr_pkg::gpr_data_t model_regs [NumRegs];
   logic               written [NumRegs];
   gpr_pkg::gpr_addr_t model_rfd;
   logic               model_commit;

   // Snapshot of the operands expected after a decode advance
   gpr_pkg::gpr_data_t exp_a;
   gpr_pkg::gpr_data_t exp_b;
   logic               check_a;
   logic               check_b;
   logic               decoded_q;
   logic               no_decode_yet;

   int unsigned        checks_done    = 0;
   int unsigned        decodes_issued = 0;
   int unsigned        fail_count     = 0;
   int unsigned        tests_passed   = 0;
   int unsigned        tests_failed   = 0;
   logic [15:0]        lfsr_state;

   always #20 clk = ~clk;

   gpr_file gpr_file_inst (
      .clk             (clk),
      .rst             (rst),
      .padv_decode_i   (padv_decode),
      .rfa_adr_i       (rfa_adr),
      .rfb_adr_i       (rfb_adr),
      .rfd_adr_i       (rfd_adr),
      .rf_wb_i         (rf_wb),
      .execute_rf_we_i (execute_rf_we),
      .write_mask_i    (write_mask),
      .result_i        (result),
      .rfa_o           (rfa),
      .rfb_o           (rfb)
   );

   // Commit first, then snapshot, so a same-edge write is visible
   always @(posedge clk) begin
      if (rst) begin
         model_rfd     <= '0;
         decoded_q     <= 1'b0;
         check_a       <= 1'b0;
         check_b       <= 1'b0;
         no_decode_yet <= 1'b1;
      end else begin
         if (decoded_q) begin
            checks_done <= checks_done + 1;
         end
         model_commit = execute_rf_we & rf_wb & ~write_mask;
         if (model_commit) begin
            model_regs[model_rfd] = result;
            written[model_rfd]    = 1'b1;
         end
         decoded_q <= padv_decode;
         check_a   <= padv_decode & written[rfa_adr];
         check_b   <= padv_decode & written[rfb_adr];
         if (padv_decode) begin
            exp_a         <= model_regs[rfa_adr];
            exp_b         <= model_regs[rfb_adr];
            model_rfd     <= rfd_adr;
            no_decode_yet <= 1'b0;
         end
      end
   end

   zero_after_reset: assert property (@(posedge clk) disable iff (rst)
      no_decode_yet |-> (rfa == '0 && rfb == '0))
   else begin
      fail_count++;
      $display("[FAIL] %0d ns: operands %h %h not zero before first decode",
               $time, $sampled(rfa), $sampled(rfb));
   end

   rfa_matches: assert property (@(posedge clk) disable iff (rst) check_a |-> rfa == exp_a)
   else begin
      fail_count++;
      $display("[FAIL] %0d ns: rfa_o is %h, expected %h", $time, $sampled(rfa),
               $sampled(exp_a));
   end

   rfb_matches: assert property (@(posedge clk) disable iff (rst) check_b |-> rfb == exp_b)
   else begin
      fail_count++;
      $display("[FAIL] %0d ns: rfb_o is %h, expected %h", $time, $sampled(rfb),
               $sampled(exp_b));
   end

   // Galois form with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 16'hB400;
      end
      return state >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] take_bits(input int unsigned count);
      logic [31:0] bits;
      bits = '0;
      for (int unsigned i = 0; i < count; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         bits       = {bits[30:0], lfsr_state[0]};
      end
      return bits;
   endfunction

   task automatic clear_strobes();
      padv_decode   = 1'b0;
      execute_rf_we = 1'b0;
      write_mask    = 1'b0;
      rf_wb         = 1'b0;
   endtask

   task automatic next_edge();
      @(posedge clk);
      #2;
      clear_strobes();
   endtask

   task automatic decode_advance(input gpr_pkg::gpr_addr_t a, input gpr_pkg::gpr_addr_t b,
                                 input gpr_pkg::gpr_addr_t d);
      padv_decode = 1'b1;
      rfa_adr     = a;
      rfb_adr     = b;
      rfd_adr     = d;
      decodes_issued++;
   endtask

   task automatic execute_write(input gpr_pkg::gpr_data_t data, input logic wb,
                                input logic mask);
      execute_rf_we = 1'b1;
      rf_wb         = wb;
      write_mask    = mask;
      result        = data;
   endtask

   // Every decode advance must have had its operands sampled
   task automatic await_checks(input string name);
      int unsigned waited;
      waited = 0;
      while (checks_done < decodes_issued && waited < CheckTimeout) begin
         next_edge();
         waited++;
      end
      if (checks_done < decodes_issued) begin
         $display("Timeout in %s: operands of a decode advance were never checked", name);
         fail_count++;
      end
   endtask

   task automatic report_test(input string name, input int unsigned fails_before);
      if (fail_count == fails_before) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, fail_count - fails_before);
      end
   endtask

   task automatic idle_after_reset();
      repeat (3) next_edge();
   endtask

   task automatic write_then_read_all();
      for (int unsigned r = 0; r < NumRegs; r++) begin
         decode_advance('0, '0, gpr_pkg::gpr_addr_t'(r));
         next_edge();
         execute_write(32'hC0DE_0000 + r * 32'h111, 1'b1, 1'b0);
         next_edge();
      end
      for (int unsigned r = 0; r < NumRegs; r++) begin
         decode_advance(gpr_pkg::gpr_addr_t'(r), gpr_pkg::gpr_addr_t'(NumRegs - 1 - r), '0);
         next_edge();
      end
      await_checks("write_read");
   endtask

   // Variant 0 port A, 1 port B, 2 both
   task automatic forward_same_edge();
      gpr_pkg::gpr_addr_t r;
      for (int unsigned v = 0; v < 3; v++) begin
         r = gpr_pkg::gpr_addr_t'(5 + v * 7);
         decode_advance('0, '0, r);
         next_edge();
         case (v)
            0: decode_advance(r, r ^ 5'd1, '0);
            1: decode_advance(r ^ 5'd1, r, '0);
            default: decode_advance(r, r, '0);
         endcase
         execute_write(32'hF00D_0000 | (v << 8) | r, 1'b1, 1'b0);
         next_edge();
         await_checks("same_edge");
      end
   endtask

   task automatic suppressed_writes();
      // Masked write
      decode_advance('0, '0, 5'd9);
      next_edge();
      execute_write(32'hDEAD_0009, 1'b1, 1'b1);
      next_edge();
      decode_advance(5'd9, 5'd9, '0);
      next_edge();
      // No writeback expected
      decode_advance('0, '0, 5'd17);
      next_edge();
      execute_write(32'hDEAD_0017, 1'b0, 1'b0);
      next_edge();
      decode_advance(5'd17, 5'd17, '0);
      next_edge();
      await_checks("suppressed");
   endtask

   task automatic random_traffic();
      logic               do_decode;
      logic               do_write;
      logic               wb;
      logic               mask;
      gpr_pkg::gpr_addr_t a;
      gpr_pkg::gpr_addr_t b;
      gpr_pkg::gpr_addr_t d;
      gpr_pkg::gpr_data_t data;
      for (int unsigned i = 0; i < RandomCycles; i++) begin
         do_decode = take_bits(1) == 1;
         a         = gpr_pkg::gpr_addr_t'(take_bits(5));
         b         = gpr_pkg::gpr_addr_t'(take_bits(5));
         d         = gpr_pkg::gpr_addr_t'(take_bits(5));
         do_write  = take_bits(1) == 1;
         wb        = take_bits(2) != 0;
         mask      = take_bits(2) == 3;
         data      = take_bits(32);
         if (do_decode) begin
            decode_advance(a, b, d);
         end
         if (do_write) begin
            execute_write(data, wb, mask);
         end
         next_edge();
      end
      await_checks("random");
   endtask

   initial begin
      int unsigned fails_before;
      lfsr_state = 16'd42146;
      for (int unsigned i = 0; i < NumRegs; i++) begin
         written[i] = 1'b0;
      end
      clear_strobes();
      rfa_adr = '0;
      rfb_adr = '0;
      rfd_adr = '0;
      result  = '0;
      rst     = 1'b1;
      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;

      fails_before = fail_count;
      idle_after_reset();
      report_test("reset_zero", fails_before);
      fails_before = fail_count;
      write_then_read_all();
      report_test("write_read", fails_before);
      fails_before = fail_count;
      forward_same_edge();
      report_test("same_edge", fails_before);
      fails_before = fail_count;
      suppressed_writes();
      report_test("suppressed", fails_before);
      fails_before = fail_count;
      random_traffic();
      report_test("random", fails_before);

      $display("tests passed %0d, tests failed %0d, operand checks %0d",
               tests_passed, tests_failed, checks_done);
      if (fail_count == 0 && tests_failed == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/gpr_file.sv
`default_nettype none

// General-purpose register file of the four-stage core
// Two banks side by side, one per read port, plus write forwarding
module gpr_file #(
   parameter int unsigned AddrWidth    = gpr_pkg::ADDR_WIDTH,
   parameter int unsigned NumWords     = gpr_pkg::NUM_WORDS,
   parameter int unsigned OperandWidth = gpr_pkg::OPERAND_WIDTH
) (
   input  logic                    clk,
   input  logic                    rst,

   // Decode stage
   input  logic                    padv_decode_i,
   input  logic [AddrWidth-1:0]    rfa_adr_i,
   input  logic [AddrWidth-1:0]    rfb_adr_i,
   input  logic [AddrWidth-1:0]    rfd_adr_i,
   input  logic                    rf_wb_i,

   // Execute stage
   input  logic                    execute_rf_we_i,
   input  logic                    write_mask_i,
   input  logic [OperandWidth-1:0] result_i,

   // Operands valid the cycle after a decode advance
   output logic [OperandWidth-1:0] rfa_o,
   output logic [OperandWidth-1:0] rfb_o
);

   // Bank outputs
   logic [OperandWidth-1:0] bank_a_data;
   logic [OperandWidth-1:0] bank_b_data;

   // Shared write port
   logic                    wr_en;
   logic [AddrWidth-1:0]    wr_adr;
   logic [OperandWidth-1:0] wr_data;

   // Port A bank
   gpr_bank #(
      .AddrWidth    (AddrWidth),
      .NumWords     (NumWords),
      .OperandWidth (OperandWidth)
   ) bank_a (
      .clk       (clk),
      .rst       (rst),
      .rd_adr_i  (rfa_adr_i),
      .rd_en_i   (padv_decode_i),
      .rd_data_o (bank_a_data),
      .wr_adr_i  (wr_adr),
      .wr_en_i   (wr_en),
      .wr_data_i (wr_data)
   );

   // Port B bank holding the same contents as port A
   gpr_bank #(
      .AddrWidth    (AddrWidth),
      .NumWords     (NumWords),
      .OperandWidth (OperandWidth)
   ) bank_b (
      .clk       (clk),
      .rst       (rst),
      .rd_adr_i  (rfb_adr_i),
      .rd_en_i   (padv_decode_i),
      .rd_data_o (bank_b_data),
      .wr_adr_i  (wr_adr),
      .wr_en_i   (wr_en),
      .wr_data_i (wr_data)
   );

   // Commit logic and operand bypass
   gpr_forward #(
      .AddrWidth    (AddrWidth),
      .OperandWidth (OperandWidth)
   ) forward (
      .clk             (clk),
      .rst             (rst),
      .padv_decode_i   (padv_decode_i),
      .rfa_adr_i       (rfa_adr_i),
      .rfb_adr_i       (rfb_adr_i),
      .rfd_adr_i       (rfd_adr_i),
      .rf_wb_i         (rf_wb_i),
      .execute_rf_we_i (execute_rf_we_i),
      .write_mask_i    (write_mask_i),
      .result_i        (result_i),
      .bank_a_data_i   (bank_a_data),
      .bank_b_data_i   (bank_b_data),
      .wr_en_o         (wr_en),
      .wr_adr_o        (wr_adr),
      .wr_data_o       (wr_data),
      .rfa_o           (rfa_o),
      .rfb_o           (rfb_o)
   );

endmodule

`default_nettype wire

// File: rtl/gpr_forward.sv
`default_nettype none

// Decode latches, write commit and operand bypass
module gpr_forward #(
   parameter int unsigned AddrWidth    = $bits(gpr_pkg::gpr_addr_t),
   parameter int unsigned OperandWidth = $bits(gpr_pkg::gpr_data_t)
) (
   input  logic                    clk,
   input  logic                    rst,

   // Decode stage
   input  logic                    padv_decode_i,
   input  logic [AddrWidth-1:0]    rfa_adr_i,
   input  logic [AddrWidth-1:0]    rfb_adr_i,
   input  logic [AddrWidth-1:0]    rfd_adr_i,
   input  logic                    rf_wb_i,

   // Execute stage
   input  logic                    execute_rf_we_i,
   input  logic                    write_mask_i,
   input  logic [OperandWidth-1:0] result_i,

   // Bank read data
   input  logic [OperandWidth-1:0] bank_a_data_i,
   input  logic [OperandWidth-1:0] bank_b_data_i,

   // Write port to both banks
   output logic                    wr_en_o,
   output logic [AddrWidth-1:0]    wr_adr_o,
   output logic [OperandWidth-1:0] wr_data_o,

   // Operands
   output logic [OperandWidth-1:0] rfa_o,
   output logic [OperandWidth-1:0] rfb_o
);

   // Register numbers latched at decode
   logic [AddrWidth-1:0]    rfa_q;
   logic [AddrWidth-1:0]    rfb_q;
   logic [AddrWidth-1:0]    rfd_q;

   // Commit strobe
   logic                    commit;

   // Last committed write
   logic                    last_valid_q;
   logic [AddrWidth-1:0]    last_adr_q;
   logic [OperandWidth-1:0] last_data_q;

   // Bypass selects
   logic                    rfa_use_last;
   logic                    rfb_use_last;

   // Source and destination numbers
   always_ff @(posedge clk) begin
      if (rst) begin
         rfa_q <= '0;
         rfb_q <= '0;
         rfd_q <= '0;
      end else if (padv_decode_i) begin
         rfa_q <= rfa_adr_i;
         rfb_q <= rfb_adr_i;
         rfd_q <= rfd_adr_i;
      end
   end

   // Write happens when execute strobes, decode expected a writeback
   // and nothing masks it
   assign commit = execute_rf_we_i & rf_wb_i & ~write_mask_i;

   // Destination is the one latched at decode, not the incoming one
   assign wr_en_o   = commit;
   assign wr_adr_o  = rfd_q;
   assign wr_data_o = result_i;

   // Valid flag of the last-write register
   always_ff @(posedge clk) begin
      if (rst) begin
         last_valid_q <= 1'b0;
      end else if (commit) begin
         last_valid_q <= 1'b1;
      end
   end

   // Number and data of the last write
   always_ff @(posedge clk) begin
      if (commit) begin
         last_adr_q  <= rfd_q;
         last_data_q <= result_i;
      end
   end

   // The bank read register misses a write on the decode edge itself
   // The last-write copy has it
   assign rfa_use_last = last_valid_q & (last_adr_q == rfa_q);
   assign rfb_use_last = last_valid_q & (last_adr_q == rfb_q);

   // Operand muxes
   assign rfa_o = rfa_use_last ? last_data_q : bank_a_data_i;
   assign rfb_o = rfb_use_last ? last_data_q : bank_b_data_i;

endmodule

`default_nettype wire

// File: rtl/gpr_bank.sv
`default_nettype none

// One bank of the register file
// Both banks see every write, each serves one read port
module gpr_bank #(
   parameter int unsigned AddrWidth    = $bits(gpr_pkg::gpr_addr_t),
   parameter int unsigned NumWords     = gpr_pkg::NUM_WORDS,
   parameter int unsigned OperandWidth = $bits(gpr_pkg::gpr_data_t)
) (
   input  logic                    clk,
   input  logic                    rst,

   // Read port loaded on decode advance
   input  logic [AddrWidth-1:0]    rd_adr_i,
   input  logic                    rd_en_i,
   output logic [OperandWidth-1:0] rd_data_o,

   // Write port from the commit logic
   input  logic [AddrWidth-1:0]    wr_adr_i,
   input  logic                    wr_en_i,
   input  logic [OperandWidth-1:0] wr_data_i
);

   // Register storage
   // Contents undefined until written
   logic [OperandWidth-1:0] mem [NumWords];

   // Output register of the read port
   logic [OperandWidth-1:0] rd_data_q;

   // Single write port
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_adr_i] <= wr_data_i;
      end
   end

   // Registered read
   // A read and write of one entry on the same edge sees the old value
   // The forwarding block covers that case
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_data_q <= '0;
      end else if (rd_en_i) begin
         rd_data_q <= mem[rd_adr_i];
      end
   end

   // Holds until the next read
   assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// File: rtl/gpr_pkg.sv
`default_nettype none

package gpr_pkg;

   // Register number width
   localparam int unsigned ADDR_WIDTH = 5;

   // Number of general-purpose registers
   localparam int unsigned NUM_WORDS = 32;

   // Operand and result width
   localparam int unsigned OPERAND_WIDTH = 32;

   // Register number as seen by decode and writeback
   typedef logic [ADDR_WIDTH-1:0] gpr_addr_t;

   // Operand or execute result
   typedef logic [OPERAND_WIDTH-1:0] gpr_data_t;

endpackage

`default_nettype wire
